// ==== common/rename_params.svh ====
// sizes of the architectural and physical register files and the retire queue.
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// architectural register file as seen by the instruction set.
`define ARCH_REG_SZ 8
`define ARCH_REG_IDX_SZ 3

// physical register file behind the rename maps.
`define PHYS_REG_SZ 32
`define PHYS_REG_IDX_SZ 5

// retire queue slots with one upstream credit per slot.
// the slot count must be a power of two so the pointers wrap on their own.
`define RQ_DEPTH 16
`define RQ_IDX_SZ 4

// PHYS_REG_SZ has to cover ARCH_REG_SZ + RQ_DEPTH.
// committed mappings hold ARCH_REG_SZ registers and every in-flight rename
// holds one more, so allocation can never find the list empty while
// upstream respects its credits.

`endif

// ==== common/rename_pkg.sv ====
// rename types for register indices, retire-queue tags and queue entries.
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    // index into the architectural register file.
    typedef logic [`ARCH_REG_IDX_SZ-1:0] arch_idx_t;

    // index into the physical register file.
    typedef logic [`PHYS_REG_IDX_SZ-1:0] phys_idx_t;

    // slot number in the retire queue, also handed back as the rename tag.
    typedef logic [`RQ_IDX_SZ-1:0] rq_tag_t;

    // one renamed instruction waiting to commit.
    // rd is the architectural destination.
    // new_pd is the register allocated for it.
    // old_pd is the mapping it replaced, freed at commit.
    typedef struct packed {
        arch_idx_t rd;
        phys_idx_t new_pd;
        phys_idx_t old_pd;
    } rq_entry_t;

endpackage

`default_nettype wire

// ==== rename/free_list.sv ====
// bitmap free list of physical registers with lowest-index pick and pass-through.
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module free_list (
    input  logic                  clk,
    input  logic                  reset,

    // no bit set in the bitmap.
    output logic                  is_empty,

    // allocation side.
    input  logic                  dequeue_en,
    output rename_pkg::phys_idx_t dequeue_pr,

    // release side, fed from commit.
    input  logic                  enqueue_en,
    input  rename_pkg::phys_idx_t enqueue_pr,

    // rollback returns every in-flight destination at once.
    input  logic                  rollback,
    input  logic [`PHYS_REG_SZ-1:0] rollback_mask
);

    // one bit per physical register where set means free.
    logic [`PHYS_REG_SZ-1:0] free_bits;

    // lowest free index from the bitmap.
    rename_pkg::phys_idx_t lowest_free;

    // list empty but a register is arriving this cycle.
    logic passthrough;

    // the arriving register is taken straight away and never lands in the bitmap.
    logic pass_taken;

    assign is_empty   = ~|free_bits;
    assign passthrough = is_empty && enqueue_en;
    assign pass_taken  = passthrough && dequeue_en;

    // priority pick scans down so the lowest set bit wins.
    always_comb begin
        lowest_free = '0;
        for (int i = `PHYS_REG_SZ - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                lowest_free = rename_pkg::phys_idx_t'(i);
            end
        end
    end

    // an empty list forwards the released register instead.
    assign dequeue_pr = passthrough ? enqueue_pr : lowest_free;

    always_ff @(posedge clk) begin
        if (reset) begin
            // registers below ARCH_REG_SZ back the identity mapping.
            for (int i = 0; i < `PHYS_REG_SZ; i++) begin
                free_bits[i] <= (i >= `ARCH_REG_SZ);
            end
        end else if (rollback) begin
            // flushed destinations become free again.
            // enqueue and dequeue are ignored in this cycle.
            free_bits <= free_bits | rollback_mask;
        end else begin
            // taking from the bitmap clears the picked bit.
            if (dequeue_en && !passthrough) begin
                free_bits[lowest_free] <= 1'b0;
            end
            // a release is kept unless it was handed on the same cycle.
            if (enqueue_en && !pass_taken) begin
                free_bits[enqueue_pr] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rename/map_table.sv ====
// rename map table holding the speculative and committed arch-to-phys maps.
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module map_table (
    input  logic                  clk,
    input  logic                  reset,

    // lookup side for the instruction being renamed.
    input  rename_pkg::arch_idx_t rs1,
    input  rename_pkg::arch_idx_t rs2,
    input  rename_pkg::arch_idx_t rd,
    output rename_pkg::phys_idx_t ps1,
    output rename_pkg::phys_idx_t ps2,
    output rename_pkg::phys_idx_t old_pd,

    // speculative update with the freshly allocated register.
    input  logic                  rename_en,
    input  rename_pkg::phys_idx_t new_pd,

    // committed update from the retire queue head.
    input  logic                  commit_en,
    input  rename_pkg::arch_idx_t commit_rd,
    input  rename_pkg::phys_idx_t commit_pd,

    // restore speculative state from committed state.
    input  logic                  rollback
);

    // mapping seen by instructions in flight.
    rename_pkg::phys_idx_t spec_map [`ARCH_REG_SZ];

    // mapping as of the last committed instruction.
    rename_pkg::phys_idx_t commit_map [`ARCH_REG_SZ];

    // three asynchronous read ports on the speculative map.
    // reads see the state before this edge, so a source equal to rd
    // gets the old mapping, which is what the instruction must read.
    assign ps1    = spec_map[rs1];
    assign ps2    = spec_map[rs2];
    assign old_pd = spec_map[rd];

    // speculative map.
    always_ff @(posedge clk) begin
        if (reset) begin
            // identity mapping puts arch register i in phys register i.
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                spec_map[i] <= rename_pkg::phys_idx_t'(i);
            end
        end else if (rollback) begin
            // throw away every uncommitted rename.
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                spec_map[i] <= commit_map[i];
            end
        end else if (rename_en) begin
            spec_map[rd] <= new_pd;
        end
    end

    // committed map.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                commit_map[i] <= rename_pkg::phys_idx_t'(i);
            end
        end else if (commit_en && !rollback) begin
            // the head's new register is now architectural state.
            commit_map[commit_rd] <= commit_pd;
        end
    end

endmodule

`default_nettype wire

// ==== rename/retire_queue.sv ====
// retire queue that records renames in order for commit frees and the rollback mask.
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module retire_queue (
    input  logic                    clk,
    input  logic                    reset,

    // rename side with one entry per accepted instruction.
    input  logic                    push,
    input  rename_pkg::rq_entry_t   push_entry,
    output rename_pkg::rq_tag_t     push_tag,

    // commit side where the head is valid whenever the queue is non-empty.
    input  logic                    pop,
    output rename_pkg::rq_entry_t   head_entry,

    // flush of everything in flight.
    input  logic                    rollback,
    output logic [`PHYS_REG_SZ-1:0] rollback_mask,

    // one pulse per commit back to upstream.
    output logic                    credit_return
);

    // entry storage for the payload only.
    rename_pkg::rq_entry_t slots [`RQ_DEPTH];

    // occupancy per slot.
    logic [`RQ_DEPTH-1:0] slot_valid;

    // oldest entry.
    rename_pkg::rq_tag_t head;

    // next slot to fill.
    rename_pkg::rq_tag_t tail;

    // the slot a push lands in doubles as the instruction's tag.
    assign push_tag   = tail;
    assign head_entry = slots[head];

    // gather the new pds of every live entry.
    // these are exactly the registers a rollback must free.
    always_comb begin
        rollback_mask = '0;
        for (int i = 0; i < `RQ_DEPTH; i++) begin
            if (slot_valid[i]) begin
                rollback_mask[slots[i].new_pd] = 1'b1;
            end
        end
    end

    // pointers and valid bits.
    always_ff @(posedge clk) begin
        if (reset) begin
            head       <= '0;
            tail       <= '0;
            slot_valid <= '0;
        end else if (rollback) begin
            // queue empties and upstream resets its credits by rule.
            head       <= '0;
            tail       <= '0;
            slot_valid <= '0;
        end else begin
            // credits keep push away from a full queue and pop away
            // from an empty one, so the two never hit the same slot.
            if (push) begin
                slot_valid[tail] <= 1'b1;
                tail             <= tail + 1'b1;
            end
            if (pop) begin
                slot_valid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
        end
    end

    // entry payload.
    always_ff @(posedge clk) begin
        if (push) begin
            slots[tail] <= push_entry;
        end
    end

    // credit goes back one cycle after the commit.
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop && !rollback;
        end
    end

endmodule

`default_nettype wire

// ==== rename/rename_unit.sv ====
// rename unit top joining free list, map table and retire queue behind a registered response.
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_unit (
    input  logic                  clk,
    input  logic                  reset,

    // rename request raised only while upstream holds a credit.
    input  logic                  rename_valid,
    input  rename_pkg::arch_idx_t rd,
    input  rename_pkg::arch_idx_t rs1,
    input  rename_pkg::arch_idx_t rs2,

    // rename response one cycle after the request.
    output logic                  out_valid,
    output rename_pkg::phys_idx_t ps1,
    output rename_pkg::phys_idx_t ps2,
    output rename_pkg::phys_idx_t pd,
    output rename_pkg::phys_idx_t old_pd,
    output rename_pkg::rq_tag_t   tag,

    // commit of the oldest entry with rd and pd valid in the same cycle.
    input  logic                  commit_en,
    output rename_pkg::arch_idx_t commit_rd,
    output rename_pkg::phys_idx_t commit_pd,

    // credit flow control.
    output logic                  credit_return,

    // discard all uncommitted renames.
    input  logic                  rollback
);

    // lookup results for the current request.
    rename_pkg::phys_idx_t map_ps1;
    rename_pkg::phys_idx_t map_ps2;
    rename_pkg::phys_idx_t map_old_pd;

    // register handed out by the free list.
    rename_pkg::phys_idx_t alloc_pd;

    // retire queue traffic.
    rename_pkg::rq_entry_t push_entry;
    rename_pkg::rq_tag_t   push_tag;
    rename_pkg::rq_entry_t head_entry;

    // in-flight destinations to free on rollback.
    logic [`PHYS_REG_SZ-1:0] rollback_mask;

    // entry records the replaced mapping so commit can free it.
    assign push_entry.rd     = rd;
    assign push_entry.new_pd = alloc_pd;
    assign push_entry.old_pd = map_old_pd;

    // head is presented combinationally for the commit.
    assign commit_rd = head_entry.rd;
    assign commit_pd = head_entry.new_pd;

    // the empty flag only matters inside the list for pass-through.
    // sizing keeps allocation from ever seeing it set.
    free_list u_free_list (
        .clk           (clk),
        .reset         (reset),
        .is_empty      (),
        .dequeue_en    (rename_valid),
        .dequeue_pr    (alloc_pd),
        .enqueue_en    (commit_en),
        .enqueue_pr    (head_entry.old_pd),
        .rollback      (rollback),
        .rollback_mask (rollback_mask)
    );

    map_table u_map_table (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .ps1       (map_ps1),
        .ps2       (map_ps2),
        .old_pd    (map_old_pd),
        .rename_en (rename_valid),
        .new_pd    (alloc_pd),
        .commit_en (commit_en),
        .commit_rd (head_entry.rd),
        .commit_pd (head_entry.new_pd),
        .rollback  (rollback)
    );

    retire_queue u_retire_queue (
        .clk           (clk),
        .reset         (reset),
        .push          (rename_valid),
        .push_entry    (push_entry),
        .push_tag      (push_tag),
        .pop           (commit_en),
        .head_entry    (head_entry),
        .rollback      (rollback),
        .rollback_mask (rollback_mask),
        .credit_return (credit_return)
    );

    // response valid.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rename_valid;
        end
    end

    // response payload, held until the next rename.
    always_ff @(posedge clk) begin
        if (rename_valid) begin
            ps1    <= map_ps1;
            ps2    <= map_ps2;
            pd     <= alloc_pd;
            old_pd <= map_old_pd;
            tag    <= push_tag;
        end
    end

endmodule

`default_nettype wire

// ==== bench/rename_checker.sv ====
// rename checker comparing the DUT against a reference model at every rising edge.
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rename_valid,
    input  rename_pkg::arch_idx_t rd,
    input  rename_pkg::arch_idx_t rs1,
    input  rename_pkg::arch_idx_t rs2,
    input  logic                  out_valid,
    input  rename_pkg::phys_idx_t ps1,
    input  rename_pkg::phys_idx_t ps2,
    input  rename_pkg::phys_idx_t pd,
    input  rename_pkg::phys_idx_t old_pd,
    input  rename_pkg::rq_tag_t   tag,
    input  logic                  commit_en,
    input  rename_pkg::arch_idx_t commit_rd,
    input  rename_pkg::phys_idx_t commit_pd,
    input  logic                  credit_return,
    input  logic                  rollback,
    output int                    errors,
    output int                    checks
);

    int err_count = 0;
    int check_count = 0;

    // speculative and committed maps of the model.
    int spec_map [`ARCH_REG_SZ];
    int commit_map [`ARCH_REG_SZ];

    // set bit means free in the model.
    logic [`PHYS_REG_SZ-1:0] free_map;
    // registers the DUT has handed out that are still mapped or in flight.
    logic [`PHYS_REG_SZ-1:0] held;

    // renamed instructions, oldest first.
    rename_pkg::rq_entry_t rq [$];
    int tag_ptr;
    int credits;

    // response due one cycle after a rename.
    logic exp_valid;
    logic exp_credit;
    int exp_ps1;
    int exp_ps2;
    int exp_pd;
    int exp_old_pd;
    int exp_tag;

    assign errors = err_count;
    assign checks = check_count;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] observed);
        check_count++;
        if (observed !== expected) begin
            err_count++;
            $display("[ERROR] %0t %s expected %0d observed %0d",
                     $time, name, expected, observed);
        end
    endtask

    task automatic flag(input string what);
        err_count++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic reset_model;
        for (int i = 0; i < `ARCH_REG_SZ; i++) begin
            spec_map[i] = i;
            commit_map[i] = i;
        end
        // identity map owns the low registers.
        for (int i = 0; i < `PHYS_REG_SZ; i++) begin
            free_map[i] = (i >= `ARCH_REG_SZ);
        end
        held = ~free_map;
        rq.delete();
        tag_ptr = 0;
        credits = `RQ_DEPTH;
        exp_valid = 1'b0;
        exp_credit = 1'b0;
    endtask

    // outputs here still hold the values from before this edge.
    task automatic check_outputs;
        compare("out_valid", exp_valid, out_valid);
        compare("credit_return", exp_credit, credit_return);
        if (exp_valid && out_valid === 1'b1) begin
            compare("ps1", exp_ps1, ps1);
            compare("ps2", exp_ps2, ps2);
            compare("pd", exp_pd, pd);
            compare("old_pd", exp_old_pd, old_pd);
            compare("tag", exp_tag, tag);
            if (held[pd]) begin
                flag($sformatf("pd %0d handed out again while still live", pd));
            end
            held[pd] = 1'b1;
        end
        if (credit_return === 1'b1) begin
            credits++;
        end
        if (commit_en) begin
            if (rq.size() == 0) begin
                flag("commit raised while the retire queue is empty");
            end else begin
                compare("commit_rd", rq[0].rd, commit_rd);
                compare("commit_pd", rq[0].new_pd, commit_pd);
            end
        end
    endtask

    task automatic update_model;
        rename_pkg::rq_entry_t entry;
        rename_pkg::rq_entry_t head;
        int alloc;
        alloc = 0;
        if (rollback) begin
            // every in-flight destination goes back and the queue empties.
            foreach (rq[i]) begin
                free_map[rq[i].new_pd] = 1'b1;
                held[rq[i].new_pd] = 1'b0;
            end
            rq.delete();
            spec_map = commit_map;
            tag_ptr = 0;
            credits = `RQ_DEPTH;
            exp_valid = 1'b0;
            exp_credit = 1'b0;
        end else begin
            if (rename_valid) begin
                if (credits == 0) begin
                    flag("rename raised without a credit");
                end
                credits--;
                // first free register counting up from zero.
                while (alloc < `PHYS_REG_SZ && !free_map[alloc]) begin
                    alloc++;
                end
                if (alloc == `PHYS_REG_SZ) begin
                    // empty list hands on the register released this cycle.
                    if (commit_en && rq.size() > 0) begin
                        alloc = rq[0].old_pd;
                    end else begin
                        flag("rename found no free physical register");
                        alloc = 0;
                    end
                end
                exp_ps1 = spec_map[rs1];
                exp_ps2 = spec_map[rs2];
                exp_old_pd = spec_map[rd];
                exp_pd = alloc;
                exp_tag = tag_ptr;
                entry.rd = rd;
                entry.new_pd = rename_pkg::phys_idx_t'(alloc);
                entry.old_pd = rename_pkg::phys_idx_t'(spec_map[rd]);
            end
            if (commit_en && rq.size() > 0) begin
                head = rq.pop_front();
                commit_map[head.rd] = head.new_pd;
                free_map[head.old_pd] = 1'b1;
                held[head.old_pd] = 1'b0;
            end
            // cleared after the release so a pass-through never stays free.
            if (rename_valid) begin
                free_map[alloc] = 1'b0;
                spec_map[rd] = alloc;
                rq.push_back(entry);
                tag_ptr = (tag_ptr + 1) % `RQ_DEPTH;
            end
            exp_valid = rename_valid;
            exp_credit = commit_en;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            check_outputs();
            update_model();
        end
    end

endmodule

`default_nettype wire

// ==== bench/rename_tb.sv ====
// rename testbench with clock, reset, seeded random stimulus and the closing summary.
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_tb;

    localparam int RANDOM_CYCLES = 3000;
    localparam int CREDIT_TIMEOUT = 40;
    localparam int MAX_CYCLES = 10000;

    logic clk;
    logic reset;
    logic rename_valid;
    rename_pkg::arch_idx_t rd;
    rename_pkg::arch_idx_t rs1;
    rename_pkg::arch_idx_t rs2;
    logic out_valid;
    rename_pkg::phys_idx_t ps1;
    rename_pkg::phys_idx_t ps2;
    rename_pkg::phys_idx_t pd;
    rename_pkg::phys_idx_t old_pd;
    rename_pkg::rq_tag_t tag;
    logic commit_en;
    rename_pkg::arch_idx_t commit_rd;
    rename_pkg::phys_idx_t commit_pd;
    logic credit_return;
    logic rollback;

    // results from the checker.
    int errors;
    int checks;

    // upstream credits, equal to the free retire-queue slots.
    int credits;
    logic [31:0] rng_state;
    logic hung = 1'b0;
    int tests_run;
    int tests_failed;
    int errors_before;

    rename_unit DUT (.*);
    rename_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_below(input int bound);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[30:16]) % bound;
    endfunction

    function automatic int in_flight();
        return `RQ_DEPTH - credits;
    endfunction

    // drive at the falling edge and collect a credit seen one cycle later.
    task automatic step(input logic ren, input int rd_v, input int rs1_v, input int rs2_v,
                        input logic com, input logic rb);
        rename_valid = ren;
        rd = rename_pkg::arch_idx_t'(rd_v);
        rs1 = rename_pkg::arch_idx_t'(rs1_v);
        rs2 = rename_pkg::arch_idx_t'(rs2_v);
        commit_en = com;
        rollback = rb;
        if (rb) begin
            credits = `RQ_DEPTH;
        end else if (ren) begin
            credits--;
        end
        @(negedge clk);
        if (credit_return) begin
            credits++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, 0, 0, 0, 1'b0, 1'b0);
    endtask

    // commits until a credit is back and stalls for the watchdog if none comes.
    task automatic wait_for_credit;
        int waited;
        waited = 0;
        while (credits == 0 && waited < CREDIT_TIMEOUT) begin
            step(1'b0, 0, 0, 0, in_flight() > 0, 1'b0);
            waited++;
        end
        if (credits == 0) begin
            hung = 1'b1;
            forever @(negedge clk);
        end
    endtask

    task automatic rename_one(input int rd_v, input int rs1_v, input int rs2_v, input logic com);
        wait_for_credit();
        step(1'b1, rd_v, rs1_v, rs2_v, com && in_flight() > 0, 1'b0);
    endtask

    task automatic end_test(input string name);
        int test_errors;
        idle(3);
        test_errors = errors - errors_before;
        errors_before = errors;
        tests_run++;
        if (test_errors > 0) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, test_errors);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (!hung && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (hung) begin
            $display("no credit came back within %0d cycles", CREDIT_TIMEOUT);
        end else begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
        end
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int pick;
        int rd_v;
        int rs1_v;
        int rs2_v;
        logic ren;
        logic com;
        rng_state = 32'h9d7f;
        credits = `RQ_DEPTH;
        tests_run = 0;
        tests_failed = 0;
        errors_before = 0;
        reset = 1'b1;
        rename_valid = 1'b0;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        commit_en = 1'b0;
        rollback = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // first registers past the identity map come out in order.
        rename_one(1, 2, 3, 1'b0);
        rename_one(2, 1, 0, 1'b0);
        rename_one(3, 2, 1, 1'b0);
        end_test("alloc");

        // a source naming rd reads the mapping being replaced.
        rename_one(1, 1, 1, 1'b0);
        rename_one(4, 4, 2, 1'b0);
        rename_one(2, 3, 2, 1'b0);
        rename_one(5, 5, 5, 1'b0);
        end_test("sources");

        // drain and refill past full so freed registers come back.
        for (int i = 0; i < 2 * `RQ_DEPTH && in_flight() > 0; i++) begin
            step(1'b0, 0, 0, 0, 1'b1, 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            rename_one(i % 8, (i + 3) % 8, (i + 5) % 8, i % 3 == 0);
        end
        end_test("commit");

        // after a flush renames read the committed map.
        rename_one(6, 6, 7, 1'b1);
        rename_one(7, 6, 6, 1'b0);
        step(1'b0, 0, 0, 0, 1'b0, 1'b1);
        for (int i = 0; i < 6; i++) begin
            rename_one(7 - i, i, 7 - i, 1'b0);
        end
        end_test("rollback");

        // mostly renames and commits with a rollback now and then.
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            pick = rand_below(100);
            rd_v = rand_below(8);
            rs1_v = rand_below(8);
            rs2_v = rand_below(8);
            ren = ((pick >= 2 && pick < 40) || (pick >= 65 && pick < 85)) && credits > 0;
            com = pick >= 40 && pick < 85 && in_flight() > 0;
            if (pick < 2) begin
                step(1'b0, 0, 0, 0, 1'b0, 1'b1);
            end else begin
                step(ren, rd_v, rs1_v, rs2_v, com, 1'b0);
            end
        end
        end_test("random");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_unit.f ====
+incdir+common
common/rename_pkg.sv
rename/free_list.sv
rename/map_table.sv
rename/retire_queue.sv
rename/rename_unit.sv
bench/rename_checker.sv
bench/rename_tb.sv
